/* test/ecc_cases.txt */
// columns: prime a px py key expected_x expected_y, all hex, one case per line
// curve y^2 = x^3 + 2x + 2 over GF(17), group order 19, G = (5,1)
// 2^31 = 3 mod 19, so a bare top bit gives 3G
00000011 00000002 00000005 00000001 80000000 0000000a 00000006
// base 5G, key = 4 mod 19, 20G = G
00000011 00000002 00000009 00000010 80000001 00000005 00000001
// key = 6 mod 19 with 17 adds, base G gives 6G
00000011 00000002 00000005 00000001 eb1665ad 00000010 0000000d
// same key on 2G gives 12G
00000011 00000002 00000006 00000003 eb1665ad 00000000 0000000b
// key = 18 mod 19 on 4G gives 72G = 15G
00000011 00000002 00000003 00000001 8000000f 00000003 00000010

/* list.f */
logic/ecc_pkg.sv
logic/step_if.sv
logic/step_rom.sv
logic/key_scanner.sv
logic/point_regs.sv
logic/ladder_ctrl.sv
logic/ecc_point_mul.sv
test/tb_ecc_point_mul.sv

/* run.sh */
#!/bin/sh
# build and run the point multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_ecc_point_mul -Mdir obj_dir -f list.f
./obj_dir/Vtb_ecc_point_mul > sim.log 2>&1
cat sim.log

if grep -qx "all tests passed" sim.log
then
    exit 0
fi
exit 1

/* test/tb_ecc_point_mul.sv */
`timescale 1ns/1ps

module tb_ecc_point_mul import ecc_pkg::*; ();

    localparam int MAX_CASES    = 16;
    localparam int CASE_WORDS   = 7;      // prime a px py key x y
    localparam int DONE_TIMEOUT = 20000;

    logic             i_clk;
    logic             i_reset;
    logic             i_start;
    logic [KEY_W-1:0] i_key;
    field_t           i_px;
    field_t           i_py;
    field_t           i_curve_a;
    logic             i_op_done;
    field_t           i_op_result;
    logic             o_busy;
    logic             o_done;
    field_op_e        o_op;
    logic             o_op_valid;
    field_t           o_operand_p;
    field_t           o_operand_q;
    field_t           o_x;
    field_t           o_y;

    logic [31:0] case_words [0:MAX_CASES*CASE_WORDS-1];
    field_t      cur_prime;
    field_t      cur_px;
    int          req_count;
    int          div_count;
    logic        first_pending;
    logic        hung;
    int          error_count = 0;

    ecc_point_mul dut0 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_key       (i_key),
        .i_px        (i_px),
        .i_py        (i_py),
        .i_curve_a   (i_curve_a),
        .i_op_done   (i_op_done),
        .i_op_result (i_op_result),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_op        (o_op),
        .o_op_valid  (o_op_valid),
        .o_operand_p (o_operand_p),
        .o_operand_q (o_operand_q),
        .o_x         (o_x),
        .o_y         (o_y)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic field_t mod_add(input field_t a, input field_t b, input field_t p);
        mod_add = field_t'(({32'd0, a} + {32'd0, b}) % {32'd0, p});
    endfunction

    function automatic field_t mod_sub(input field_t a, input field_t b, input field_t p);
        mod_sub = field_t'(({32'd0, a} + {32'd0, p} - {32'd0, b}) % {32'd0, p});
    endfunction

    function automatic field_t mod_mul(input field_t a, input field_t b, input field_t p);
        mod_mul = field_t'(({32'd0, a} * {32'd0, b}) % {32'd0, p});
    endfunction

    // square and multiply from the lsb
    function automatic field_t mod_pow(input field_t base, input field_t expo, input field_t p);
        field_t result;
        field_t sq;
        int     i;
        result = field_t'(1);
        sq     = base;
        for (i = 0; i < FIELD_W; i++)
        begin
            if (expo[i])
                result = mod_mul(result, sq, p);
            sq = mod_mul(sq, sq, p);
        end
        mod_pow = result;
    endfunction

    function automatic field_t gfau_compute(input field_op_e op, input field_t a,
                                            input field_t b, input field_t p);
        case (op)
            FOP_ADD: gfau_compute = mod_add(a, b, p);
            FOP_SUB: gfau_compute = mod_sub(a, b, p);
            FOP_MUL: gfau_compute = mod_mul(a, b, p);
            default: gfau_compute = mod_mul(a, mod_pow(b, p - 2, p), p);   // fermat inverse
        endcase
    endfunction

    function automatic int count_ones(input logic [KEY_W-1:0] key);
        int n;
        int i;
        n = 0;
        for (i = 0; i < KEY_W - 1; i++)
            if (key[i])
                n++;
        count_ones = n;
    endfunction

    // GFAU model with a random reply delay of 0 to 5 cycles
    initial
    begin
        field_t reply_val;
        int     reply_wait;
        i_op_done   = 1'b0;
        i_op_result = '0;
        reply_val   = '0;
        reply_wait  = 0;
        forever
        begin
            @(posedge i_clk);
            i_op_done <= 1'b0;
            if (reply_wait > 0)
            begin
                reply_wait = reply_wait - 1;
                if (reply_wait == 0)
                begin
                    i_op_done   <= 1'b1;
                    i_op_result <= reply_val;
                end
            end
            else if (o_op_valid === 1'b1 && i_op_done === 1'b0)
            begin
                if (first_pending && (o_op != FOP_MUL || o_operand_p !== cur_px ||
                                      o_operand_q !== cur_px))
                begin
                    $display("FAILED at %0t: first request %s p=%h q=%h, expected FOP_MUL on %h",
                             $time, o_op.name(), o_operand_p, o_operand_q, cur_px);
                    error_count++;
                end
                first_pending = 1'b0;
                req_count++;
                if (o_op == FOP_DIV)
                    div_count++;
                reply_val  = gfau_compute(o_op, o_operand_p, o_operand_q, cur_prime);
                reply_wait = $urandom % 6;
                if (reply_wait == 0)
                begin
                    i_op_done   <= 1'b1;
                    i_op_result <= reply_val;
                end
            end
        end
    end

    task automatic check_quiet(input string where);
        if (o_op_valid !== 1'b0 || o_done !== 1'b0 || o_busy !== 1'b0)
        begin
            $display("FAILED at %0t: %s, valid=%b done=%b busy=%b, expected all low",
                     $time, where, o_op_valid, o_done, o_busy);
            error_count++;
        end
    endtask

    task automatic run_case(input int idx);
        field_t           ex;
        field_t           ey;
        logic [KEY_W-1:0] key;
        int               ones;
        int               cycles;
        int               stray_at;
        logic             done_seen;
        key      = case_words[idx*CASE_WORDS+4];
        ex       = case_words[idx*CASE_WORDS+5];
        ey       = case_words[idx*CASE_WORDS+6];
        ones     = count_ones(key);
        stray_at = 20 + ($urandom % 200);   // start pulse while busy
        @(posedge i_clk);
        cur_prime     = case_words[idx*CASE_WORDS];
        cur_px        = case_words[idx*CASE_WORDS+2];
        req_count     = 0;
        div_count     = 0;
        first_pending = 1'b1;
        i_curve_a <= case_words[idx*CASE_WORDS+1];
        i_px      <= case_words[idx*CASE_WORDS+2];
        i_py      <= case_words[idx*CASE_WORDS+3];
        i_key     <= key;
        i_start   <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        @(posedge i_clk);
        if (o_busy !== 1'b1 || o_op_valid !== 1'b0)
        begin
            $display("FAILED at %0t: case %0d busy=%b valid=%b one cycle after start",
                     $time, idx, o_busy, o_op_valid);
            error_count++;
        end
        cycles    = 0;
        done_seen = 1'b0;
        while (!done_seen && cycles < DONE_TIMEOUT)
        begin
            @(posedge i_clk);
            cycles++;
            i_start <= (cycles == stray_at);
            if (o_done === 1'b1)
                done_seen = 1'b1;
        end
        if (!done_seen)
        begin
            $display("case %0d: o_done never came within %0d cycles", idx, DONE_TIMEOUT);
            error_count++;
            hung = 1'b1;
            return;
        end
        if (o_x !== ex || o_y !== ey)
        begin
            $display("FAILED at %0t: case %0d result (%h,%h), expected (%h,%h)",
                     $time, idx, o_x, o_y, ex, ey);
            error_count++;
        end
        if (o_busy !== 1'b0)
        begin
            $display("FAILED at %0t: case %0d o_busy still high with o_done", $time, idx);
            error_count++;
        end
        if (req_count != 12 * (KEY_W - 1) + 9 * ones || div_count != KEY_W - 1 + ones)
        begin
            $display("FAILED at %0t: case %0d %0d requests %0d divides, expected %0d and %0d",
                     $time, idx, req_count, div_count, 12 * (KEY_W - 1) + 9 * ones,
                     KEY_W - 1 + ones);
            error_count++;
        end
        repeat (4)
        begin
            @(posedge i_clk);
            check_quiet($sformatf("case %0d after done", idx));
            if (o_x !== ex || o_y !== ey)
            begin
                $display("FAILED at %0t: case %0d result not held after done", $time, idx);
                error_count++;
            end
        end
    endtask

    initial
    begin
        int n_cases;
        int i;
        void'($urandom(32'ha2e8eb9b));
        i_reset       = 1'b0;
        i_start       = 1'b0;
        i_key         = '0;
        i_px          = '0;
        i_py          = '0;
        i_curve_a     = '0;
        cur_prime     = field_t'(1);
        cur_px        = '0;
        req_count     = 0;
        div_count     = 0;
        first_pending = 1'b0;
        hung          = 1'b0;
        $readmemh("test/ecc_cases.txt", case_words);
        repeat (5)
            @(posedge i_clk);
        check_quiet("in reset");
        i_reset <= 1'b1;
        repeat (3)
        begin
            @(posedge i_clk);
            check_quiet("after reset");
        end
        n_cases = 0;
        while (n_cases < MAX_CASES && case_words[n_cases*CASE_WORDS] !== '0 &&
               !$isunknown(case_words[n_cases*CASE_WORDS]))
            n_cases++;
        if (n_cases == 0)
        begin
            $display("no cases could be read from test/ecc_cases.txt");
            error_count++;
        end
        for (i = 0; i < n_cases && !hung; i++)
            run_case(i);
        $display("cases run: %0d, errors: %0d", n_cases, error_count);
        if (error_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* logic/ecc_point_mul.sv */
`timescale 1ns/1ps

module ecc_point_mul import ecc_pkg::*; (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_start,
    input  logic [KEY_W-1:0] i_key,
    input  field_t           i_px,
    input  field_t           i_py,
    input  field_t           i_curve_a,
    input  logic             i_op_done,
    input  field_t           i_op_result,
    output logic             o_busy,
    output logic             o_done,
    output field_op_e        o_op,
    output logic             o_op_valid,
    output field_t           o_operand_p,
    output field_t           o_operand_q,
    output field_t           o_x,
    output field_t           o_y
);

    logic key_load;
    logic key_shift;
    logic key_bit;
    logic key_last;

    step_if step_bus ();

    key_scanner u_key_scanner (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_load  (key_load),
        .i_key   (i_key),
        .i_shift (key_shift),
        .o_bit   (key_bit),
        .o_last  (key_last)
    );

    ladder_ctrl u_ladder_ctrl (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_key_bit   (key_bit),
        .i_key_last  (key_last),
        .i_op_done   (i_op_done),
        .o_key_load  (key_load),
        .o_key_shift (key_shift),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_op_valid  (o_op_valid),
        .o_op        (o_op),
        .step_bus    (step_bus.ctrl)
    );

    point_regs u_point_regs (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_px        (i_px),
        .i_py        (i_py),
        .i_curve_a   (i_curve_a),
        .i_op_result (i_op_result),
        .step_bus    (step_bus.regs),
        .o_operand_p (o_operand_p),
        .o_operand_q (o_operand_q),
        .o_x         (o_x),
        .o_y         (o_y)
    );

endmodule

/* logic/ladder_ctrl.sv */
`timescale 1ns/1ps

module ladder_ctrl import ecc_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_start,
    input  logic      i_key_bit,
    input  logic      i_key_last,
    input  logic      i_op_done,
    output logic      o_key_load,
    output logic      o_key_shift,
    output logic      o_busy,
    output logic      o_done,
    output logic      o_op_valid,
    output field_op_e o_op,
    step_if.ctrl      step_bus
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,       // request low for one cycle
        ST_WAIT         // request held until done
    } state_e;

    state_e    state;
    step_e     cur_step;
    step_e     next_step;
    micro_op_t micro;
    logic      op_done;
    logic      iter_end;

    step_rom u_step_rom (
        .i_step  (cur_step),
        .o_micro (micro)
    );

    assign op_done  = (state == ST_WAIT) && i_op_done;   // done outside a request is dropped
    assign iter_end = (cur_step == STEP_ADD8) ||
                      ((cur_step == STEP_DBL11) && !i_key_bit);

    assign next_step = step_e'(cur_step + 1'b1);    // DBL11 runs on into ADD0

    assign o_key_load  = (state == ST_IDLE) && i_start;
    assign o_key_shift = op_done && iter_end;
    assign o_op_valid  = (state == ST_WAIT);
    assign o_op        = micro.op;

    assign step_bus.micro     = micro;
    assign step_bus.wb        = op_done;
    assign step_bus.load      = o_key_load;
    assign step_bus.next_iter = (state == ST_ISSUE) && (cur_step == STEP_DBL0);

    always_ff @(posedge i_clk or negedge i_reset)
    begin
        if (!i_reset)
        begin
            state    <= ST_IDLE;
            cur_step <= STEP_DBL0;
            o_busy   <= 1'b0;
            o_done   <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            case (state)
                ST_IDLE:
                    if (i_start)
                    begin
                        state    <= ST_ISSUE;
                        cur_step <= STEP_DBL0;
                        o_busy   <= 1'b1;
                    end
                ST_ISSUE:
                    state <= ST_WAIT;
                ST_WAIT:
                    if (i_op_done)
                    begin
                        if (!iter_end)
                        begin
                            cur_step <= next_step;
                            state    <= ST_ISSUE;
                        end
                        else if (i_key_last)
                        begin
                            state  <= ST_IDLE;   // x3/y3 written on this edge
                            o_busy <= 1'b0;
                            o_done <= 1'b1;
                        end
                        else
                        begin
                            cur_step <= STEP_DBL0;
                            state    <= ST_ISSUE;
                        end
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* logic/point_regs.sv */
`timescale 1ns/1ps

module point_regs import ecc_pkg::*; (
    input  logic   i_clk,
    input  logic   i_reset,
    input  field_t i_px,
    input  field_t i_py,
    input  field_t i_curve_a,
    input  field_t i_op_result,
    step_if.regs   step_bus,
    output field_t o_operand_p,
    output field_t o_operand_q,
    output field_t o_x,
    output field_t o_y
);

    field_t x1, y1;     // accumulator
    field_t x2, y2;     // base point
    field_t x3, y3;     // result of the current double or add
    field_t r1, r2;
    field_t a_reg;

    function automatic field_t pick(input src_e src);
        case (src)
            SRC_X1:  pick = x1;
            SRC_Y1:  pick = y1;
            SRC_X2:  pick = x2;
            SRC_Y2:  pick = y2;
            SRC_R1:  pick = r1;
            SRC_R2:  pick = r2;
            SRC_A:   pick = a_reg;
            default: pick = '0;
        endcase
    endfunction

    always_comb
    begin
        o_operand_p = pick(step_bus.micro.src_p);
        o_operand_q = pick(step_bus.micro.src_q);
    end

    always_ff @(posedge i_clk)
    begin
        if (step_bus.load)
        begin
            x2    <= i_px;
            y2    <= i_py;
            a_reg <= i_curve_a;
        end
        if (step_bus.next_iter)
        begin
            x1 <= x3;
            y1 <= y3;
        end
        if (step_bus.wb)
        begin
            if (step_bus.micro.dst == DST_R1)
                r1 <= i_op_result;
            else
                r2 <= i_op_result;
            // a finished double becomes the accumulator for the add
            if (step_bus.micro.dst == DST_R2_Y3)
            begin
                x1 <= x3;
                y1 <= i_op_result;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_reset)
    begin
        if (!i_reset)
        begin
            x3 <= '0;
            y3 <= '0;
        end
        else if (step_bus.load)
        begin
            x3 <= i_px;
            y3 <= i_py;
        end
        else if (step_bus.wb && step_bus.micro.dst == DST_R2_X3)
            x3 <= i_op_result;
        else if (step_bus.wb && step_bus.micro.dst == DST_R2_Y3)
            y3 <= i_op_result;
    end

    assign o_x = x3;
    assign o_y = y3;

endmodule

/* logic/key_scanner.sv */
`timescale 1ns/1ps

module key_scanner import ecc_pkg::*; (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_load,
    input  logic [KEY_W-1:0] i_key,
    input  logic             i_shift,
    output logic             o_bit,
    output logic             o_last
);

    logic [KEY_W-2:0]     key_sr;     // msb is the bit in work
    logic [KEY_CNT_W-1:0] bit_cnt;

    always_ff @(posedge i_clk or negedge i_reset)
    begin
        if (!i_reset)
        begin
            key_sr  <= '0;
            bit_cnt <= '0;
        end
        else if (i_load)
        begin
            key_sr  <= i_key[KEY_W-2:0];   // top bit taken as 1
            bit_cnt <= '0;
        end
        else if (i_shift)
        begin
            key_sr  <= {key_sr[KEY_W-3:0], 1'b0};
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign o_bit  = key_sr[KEY_W-2];
    assign o_last = (bit_cnt == KEY_CNT_W'(KEY_W - 2));   // key bit 0

endmodule

/* logic/step_rom.sv */
`timescale 1ns/1ps

module step_rom import ecc_pkg::*; (
    input  step_e     i_step,
    output micro_op_t o_micro
);

    // lambda of a double is (3*x1^2 + a) / (2*y1)
    // lambda of an add is (y2 - y1) / (x2 - x1)
    always_comb
    begin
        case (i_step)
            STEP_DBL0:  o_micro = '{FOP_MUL, SRC_X1, SRC_X1, DST_R1};     // x1^2
            STEP_DBL1:  o_micro = '{FOP_ADD, SRC_R1, SRC_R1, DST_R2};
            STEP_DBL2:  o_micro = '{FOP_ADD, SRC_R1, SRC_R2, DST_R1};     // 3*x1^2
            STEP_DBL3:  o_micro = '{FOP_ADD, SRC_R1, SRC_A,  DST_R1};
            STEP_DBL4:  o_micro = '{FOP_ADD, SRC_Y1, SRC_Y1, DST_R2};     // 2*y1
            STEP_DBL5:  o_micro = '{FOP_DIV, SRC_R1, SRC_R2, DST_R1};     // lambda
            STEP_DBL6:  o_micro = '{FOP_MUL, SRC_R1, SRC_R1, DST_R2};
            STEP_DBL7:  o_micro = '{FOP_SUB, SRC_R2, SRC_X1, DST_R2};
            STEP_DBL8:  o_micro = '{FOP_SUB, SRC_R2, SRC_X1, DST_R2_X3};  // x3
            STEP_DBL9:  o_micro = '{FOP_SUB, SRC_X1, SRC_R2, DST_R2};
            STEP_DBL10: o_micro = '{FOP_MUL, SRC_R1, SRC_R2, DST_R2};
            STEP_DBL11: o_micro = '{FOP_SUB, SRC_R2, SRC_Y1, DST_R2_Y3};  // y3
            STEP_ADD0:  o_micro = '{FOP_SUB, SRC_X2, SRC_X1, DST_R1};
            STEP_ADD1:  o_micro = '{FOP_SUB, SRC_Y2, SRC_Y1, DST_R2};
            STEP_ADD2:  o_micro = '{FOP_DIV, SRC_R2, SRC_R1, DST_R1};     // lambda
            STEP_ADD3:  o_micro = '{FOP_MUL, SRC_R1, SRC_R1, DST_R2};
            STEP_ADD4:  o_micro = '{FOP_SUB, SRC_R2, SRC_X1, DST_R2};
            STEP_ADD5:  o_micro = '{FOP_SUB, SRC_R2, SRC_X2, DST_R2_X3};  // x3
            STEP_ADD6:  o_micro = '{FOP_SUB, SRC_X1, SRC_R2, DST_R2};
            STEP_ADD7:  o_micro = '{FOP_MUL, SRC_R1, SRC_R2, DST_R2};
            STEP_ADD8:  o_micro = '{FOP_SUB, SRC_R2, SRC_Y1, DST_R2_Y3};  // y3
            default:    o_micro = '{FOP_ADD, SRC_R1, SRC_R1, DST_R1};
        endcase
    end

endmodule

/* logic/step_if.sv */
`timescale 1ns/1ps

interface step_if import ecc_pkg::*; ();

    micro_op_t micro;       // op of the current step
    logic      wb;          // write gfau result to micro.dst
    logic      load;        // latch base point and curve a
    logic      next_iter;   // new iteration copies x3/y3 into x1/y1

    modport ctrl (
        output micro,
        output wb,
        output load,
        output next_iter
    );

    modport regs (
        input micro,
        input wb,
        input load,
        input next_iter
    );

endinterface

/* logic/ecc_pkg.sv */
package ecc_pkg;

    localparam int FIELD_W   = 32;
    localparam int KEY_W     = 32;
    localparam int KEY_CNT_W = $clog2(KEY_W);

    typedef logic [FIELD_W-1:0] field_t;

    // GFAU opcode
    typedef enum logic [1:0] {
        FOP_ADD = 2'd0,
        FOP_SUB = 2'd1,
        FOP_MUL = 2'd2,
        FOP_DIV = 2'd3
    } field_op_e;

    typedef enum logic [4:0] {
        STEP_DBL0,
        STEP_DBL1,
        STEP_DBL2,
        STEP_DBL3,
        STEP_DBL4,
        STEP_DBL5,
        STEP_DBL6,
        STEP_DBL7,
        STEP_DBL8,
        STEP_DBL9,
        STEP_DBL10,
        STEP_DBL11,
        STEP_ADD0,
        STEP_ADD1,
        STEP_ADD2,
        STEP_ADD3,
        STEP_ADD4,
        STEP_ADD5,
        STEP_ADD6,
        STEP_ADD7,
        STEP_ADD8
    } step_e;

    typedef enum logic [2:0] {
        SRC_X1,
        SRC_Y1,
        SRC_X2,
        SRC_Y2,
        SRC_R1,
        SRC_R2,
        SRC_A
    } src_e;

    typedef enum logic [1:0] {
        DST_R1,
        DST_R2,
        DST_R2_X3,      // r2 and x3
        DST_R2_Y3       // r2 and y3
    } dst_e;

    typedef struct packed {
        field_op_e op;
        src_e      src_p;
        src_e      src_q;
        dst_e      dst;
    } micro_op_t;

endpackage
